// ==== verilog/regbank_config.svh ====
// Register bank configuration with address width and bytes per word
`ifndef REGBANK_CONFIG_SVH
`define REGBANK_CONFIG_SVH

// Word address width
// 4 bits gives a bank of 16 words
`define REGBANK_ADDR_W 4

// Bytes per word
// The word width is 8 times this
`define REGBANK_BYTES 4

// Word width and bank depth derived from the above
`define REGBANK_WORD_W (8 * `REGBANK_BYTES)
`define REGBANK_DEPTH  (1 << `REGBANK_ADDR_W)

`endif

// ==== verilog/regbank_pkg.sv ====
// Register bank types: word address, byte enables and the two-view data word
`include "regbank_config.svh"

package regbank_pkg;

    // Word address into the bank
    typedef logic [`REGBANK_ADDR_W-1:0] addr_t;

    // One write enable per byte lane
    // Bit i covers byte i of the word
    typedef logic [`REGBANK_BYTES-1:0] byte_en_t;

    // One data word, decoded two ways
    // whole: flat value, used by the storage and the read port
    // bytes: per-lane view, used by the byte merge
    // Lane 0 is the least significant byte in both views
    typedef union packed {
        logic [`REGBANK_WORD_W-1:0]     whole;
        logic [`REGBANK_BYTES-1:0][7:0] bytes;
    } word_t;

endpackage

// ==== verilog/reg_bank.sv ====
// Register storage: one write port, two combinational read ports, clear on reset
`timescale 1ns/100ps
`include "regbank_config.svh"

module reg_bank (
    input  logic               clk,
    input  logic               rst,

    // Write port, one word per clock
    input  logic               we,
    input  regbank_pkg::addr_t waddr,
    input  regbank_pkg::word_t wword,

    // Read port A, external reader
    input  regbank_pkg::addr_t raddr_a,
    output regbank_pkg::word_t rword_a,

    // Read port B, read-modify-write path
    input  regbank_pkg::addr_t raddr_b,
    output regbank_pkg::word_t rword_b
);

    // Flat word storage
    logic [`REGBANK_WORD_W-1:0] mem [`REGBANK_DEPTH];

    // Reset clears every word
    // Otherwise one write per clock when enabled
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REGBANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wword.whole;
        end
    end

    // Read ports see the array as it stands
    // A write shows up right after its edge
    always_comb begin
        rword_a.whole = mem[raddr_a];
    end

    always_comb begin
        rword_b.whole = mem[raddr_b];
    end

endmodule

// ==== verilog/rmw_read_stage.sv ====
// Read stage of the write pipeline that captures the request, fetches the old word and forwards
`timescale 1ns/100ps

module rmw_read_stage (
    input  logic                  clk,
    input  logic                  rst,

    // Write request sampled every edge
    input  regbank_pkg::addr_t    wr_addr,
    input  regbank_pkg::byte_en_t wr_be,
    input  regbank_pkg::word_t    wr_data,

    // Bank read for the old word
    output regbank_pkg::addr_t    rmw_addr,
    input  regbank_pkg::word_t    rmw_word,

    // In-flight merge result from the next stage
    input  logic                  fwd_valid,
    input  regbank_pkg::addr_t    fwd_addr,
    input  regbank_pkg::word_t    fwd_word,

    // Request plus old word for the merge stage
    output regbank_pkg::addr_t    s2_addr,
    output regbank_pkg::byte_en_t s2_be,
    output regbank_pkg::word_t    s2_data,
    output regbank_pkg::word_t    s2_old
);

    // Stage 1 rank holding the captured request
    regbank_pkg::addr_t    s1_addr;
    regbank_pkg::byte_en_t s1_be;
    regbank_pkg::word_t    s1_data;

    // Old word after the forwarding choice
    regbank_pkg::word_t    old_word;
    logic                  fwd_hit;

    // Enables are the only control state here
    // Zero enables make the request an idle slot
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_be <= '0;
            s2_be <= '0;
        end else begin
            s1_be <= wr_be;
            s2_be <= s1_be;
        end
    end

    // Payload ranks for address and data
    always_ff @(posedge clk) begin
        s1_addr <= wr_addr;
        s1_data <= wr_data;
    end

    // Bank lookup uses the stage 1 address
    assign rmw_addr = s1_addr;

    // The previous request is being written back this cycle
    // Same address means the bank still holds the stale word
    assign fwd_hit = fwd_valid && (fwd_addr == s1_addr);

    // Pick the fresh merge result over the bank contents
    always_comb begin
        if (fwd_hit) begin
            old_word = fwd_word;
        end else begin
            old_word = rmw_word;
        end
    end

    // Stage 2 rank
    // Request and old word move together
    always_ff @(posedge clk) begin
        s2_addr <= s1_addr;
        s2_data <= s1_data;
        s2_old  <= old_word;
    end

endmodule

// ==== verilog/byte_merge_stage.sv ====
// Merge stage of the write pipeline: overlays enabled request bytes on the old word
`timescale 1ns/100ps
`include "regbank_config.svh"

module byte_merge_stage (
    // Registered request and old word from the read stage
    input  regbank_pkg::addr_t    s2_addr,
    input  regbank_pkg::byte_en_t s2_be,
    input  regbank_pkg::word_t    s2_data,
    input  regbank_pkg::word_t    s2_old,

    // Bank write port, also fed back as the forward path
    output logic                  bank_we,
    output regbank_pkg::addr_t    bank_addr,
    output regbank_pkg::word_t    bank_word
);

    regbank_pkg::word_t merged;

    // Per-lane select through the bytes view
    // Enabled lane takes new data, the rest keep the old value
    always_comb begin
        for (int i = 0; i < `REGBANK_BYTES; i++) begin
            if (s2_be[i]) begin
                merged.bytes[i] = s2_data.bytes[i];
            end else begin
                merged.bytes[i] = s2_old.bytes[i];
            end
        end
    end

    // Write only when some lane is enabled
    // An idle slot neither writes nor forwards
    assign bank_we   = |s2_be;

    // Address passes straight to the bank
    assign bank_addr = s2_addr;

    assign bank_word = merged;

endmodule

// ==== verilog/regbank_byteen_top.sv ====
// Byte-writable register bank top: read stage, merge stage and storage joined
`timescale 1ns/100ps

module regbank_byteen_top (
    input  logic                  clk,
    input  logic                  rst,

    // Write request, taken every clock
    input  regbank_pkg::addr_t    wr_addr,
    input  regbank_pkg::byte_en_t wr_be,
    input  regbank_pkg::word_t    wr_data,

    // Combinational read port
    input  regbank_pkg::addr_t    rd_addr,
    output regbank_pkg::word_t    rd_data
);

    // Old word lookup between read stage and bank
    regbank_pkg::addr_t    rmw_addr;
    regbank_pkg::word_t    rmw_word;

    // Stage 2 request and old word
    regbank_pkg::addr_t    s2_addr;
    regbank_pkg::byte_en_t s2_be;
    regbank_pkg::word_t    s2_data;
    regbank_pkg::word_t    s2_old;

    // Merge result, doubles as the forward path
    logic                  bank_we;
    regbank_pkg::addr_t    bank_addr;
    regbank_pkg::word_t    bank_word;

    // Request capture, old word fetch and forwarding
    rmw_read_stage rmw_read_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .wr_addr   (wr_addr),
        .wr_be     (wr_be),
        .wr_data   (wr_data),
        .rmw_addr  (rmw_addr),
        .rmw_word  (rmw_word),
        .fwd_valid (bank_we),
        .fwd_addr  (bank_addr),
        .fwd_word  (bank_word),
        .s2_addr   (s2_addr),
        .s2_be     (s2_be),
        .s2_data   (s2_data),
        .s2_old    (s2_old)
    );

    // Byte overlay and write back
    byte_merge_stage byte_merge_stage_inst (
        .s2_addr   (s2_addr),
        .s2_be     (s2_be),
        .s2_data   (s2_data),
        .s2_old    (s2_old),
        .bank_we   (bank_we),
        .bank_addr (bank_addr),
        .bank_word (bank_word)
    );

    // Port A serves the outside, port B the pipeline
    reg_bank reg_bank_inst (
        .clk     (clk),
        .rst     (rst),
        .we      (bank_we),
        .waddr   (bank_addr),
        .wword   (bank_word),
        .raddr_a (rd_addr),
        .rword_a (rd_data),
        .raddr_b (rmw_addr),
        .rword_b (rmw_word)
    );

endmodule

// ==== sim/regbank_byteen_tb.sv ====
// Testbench for the byte-writable register bank with trace replay and a random shadow-model phase
`timescale 1ns/100ps
`include "regbank_config.svh"

module regbank_byteen_tb;

    localparam int MAX_OPS  = 64;
    localparam int RAND_OPS = 200;
    localparam int NAME_W   = 8 * 24;

    logic                  clk;
    logic                  rst;
    regbank_pkg::addr_t    wr_addr;
    regbank_pkg::byte_en_t wr_be;
    regbank_pkg::word_t    wr_data;
    regbank_pkg::addr_t    rd_addr;
    regbank_pkg::word_t    rd_data;

    // Trace operations parsed at time zero
    logic [7:0]            op_kind [MAX_OPS];
    logic [NAME_W-1:0]     op_name [MAX_OPS];
    regbank_pkg::addr_t    op_addr [MAX_OPS];
    regbank_pkg::byte_en_t op_be   [MAX_OPS];
    regbank_pkg::word_t    op_word [MAX_OPS];
    int                    op_count;
    bit                    trace_ready;

    // Expected bank contents
    regbank_pkg::word_t    shadow [`REGBANK_DEPTH];

    // Random requests kept until they reach the bank
    regbank_pkg::addr_t    rq_addr [RAND_OPS];
    regbank_pkg::byte_en_t rq_be   [RAND_OPS];
    regbank_pkg::word_t    rq_data [RAND_OPS];

    int                    checks_passed;
    int                    checks_failed;

    regbank_byteen_top regbank_byteen_top_inst (
        .clk     (clk),
        .rst     (rst),
        .wr_addr (wr_addr),
        .wr_be   (wr_be),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Byte overlay as a lane mask on the flat word
    function automatic regbank_pkg::word_t overlay_bytes(regbank_pkg::word_t old_w,
                                                         regbank_pkg::byte_en_t be,
                                                         regbank_pkg::word_t new_w);
        logic [`REGBANK_WORD_W-1:0] mask;
        regbank_pkg::word_t         result;
        mask = '0;
        for (int b = 0; b < `REGBANK_BYTES; b++) begin
            if (be[b]) begin
                mask[8*b +: 8] = 8'hff;
            end
        end
        result.whole = (old_w.whole & ~mask) | (new_w.whole & mask);
        return result;
    endfunction

    task automatic check_word(input logic [NAME_W-1:0] name,
                              input regbank_pkg::word_t expected,
                              input regbank_pkg::word_t actual,
                              output bit ok);
        ok = (actual.whole === expected.whole);
        if (ok) begin
            checks_passed++;
        end else begin
            checks_failed++;
            $display("FAIL %0s expected %08h actual %08h", name, expected.whole, actual.whole);
        end
    endtask

    // One operation per line
    // Comment and blank lines are skipped
    task automatic load_trace(output bit ok);
        int                fd;
        int                n;
        logic [8*128-1:0]  line_buf;
        logic [7:0]        kind_buf;
        logic [NAME_W-1:0] name_buf;
        logic [31:0]       f_a;
        logic [31:0]       f_b;
        logic [31:0]       f_c;
        op_count = 0;
        fd = $fopen("sim/regbank_trace.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd) && op_count < MAX_OPS) begin
                line_buf = '0;
                kind_buf = "#";
                n = $fgets(line_buf, fd);
                if (n > 0) begin
                    n = $sscanf(line_buf, "%s %s %h %h %h", kind_buf, name_buf, f_a, f_b, f_c);
                end
                // W lines carry five fields and R lines four
                if ((kind_buf == "W" && n == 5) || (kind_buf == "R" && n >= 4)) begin
                    op_kind[op_count] = kind_buf;
                    op_name[op_count] = name_buf;
                    op_addr[op_count] = f_a[`REGBANK_ADDR_W-1:0];
                    if (kind_buf == "W") begin
                        op_be[op_count]         = f_b[`REGBANK_BYTES-1:0];
                        op_word[op_count].whole = f_c;
                    end else begin
                        op_be[op_count]         = '0;
                        op_word[op_count].whole = f_b;
                    end
                    op_count++;
                end
            end
            $fclose(fd);
            ok = (op_count > 0);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int a = 0; a < `REGBANK_DEPTH; a++) begin
            shadow[a] = '0;
        end
    endtask

    // Every word reads zero straight after reset
    task automatic check_reset();
        bit                 ok;
        bit                 all_ok;
        regbank_pkg::word_t zero_word;
        all_ok          = 1'b1;
        zero_word.whole = '0;
        for (int a = 0; a < `REGBANK_DEPTH; a++) begin
            rd_addr = regbank_pkg::addr_t'(a);
            @(negedge clk);
            check_word("reset_clear", zero_word, rd_data, ok);
            if (!ok) begin
                all_ok = 1'b0;
            end
        end
        if (all_ok) begin
            $display("PASS reset_clear");
        end else begin
            $display("DONE reset_clear with nonzero words");
        end
    endtask

    task automatic replay_trace();
        bit ok;
        for (int i = 0; i < op_count; i++) begin
            if (op_kind[i] == "W") begin
                // Request held for exactly one rising edge
                wr_addr = op_addr[i];
                wr_be   = op_be[i];
                wr_data = op_word[i];
                shadow[op_addr[i]] = overlay_bytes(shadow[op_addr[i]], op_be[i], op_word[i]);
                @(negedge clk);
            end else begin
                // Two idle edges drain the last write into the bank
                wr_be = '0;
                @(negedge clk);
                @(negedge clk);
                rd_addr = op_addr[i];
                @(negedge clk);
                check_word(op_name[i], op_word[i], rd_data, ok);
                if (ok) begin
                    $display("PASS %0s", op_name[i]);
                end
            end
        end
    endtask

    // Back-to-back requests with a read checked against the shadow every cycle
    task automatic run_random();
        bit                 ok;
        int                 mismatches;
        int                 pick;
        regbank_pkg::addr_t hot [4];
        regbank_pkg::addr_t last_addr;
        mismatches = 0;
        last_addr  = '0;
        for (int h = 0; h < 4; h++) begin
            hot[h] = regbank_pkg::addr_t'($urandom);
        end
        for (int k = 0; k < RAND_OPS + 3; k++) begin
            // Read set one edge ago sees every request up to k-3
            if (k > 0) begin
                check_word("random_rmw", shadow[rd_addr], rd_data, ok);
                if (!ok) begin
                    mismatches++;
                end
            end
            // Request k-2 lands in the bank at the coming rising edge
            if (k >= 2 && k - 2 < RAND_OPS) begin
                shadow[rq_addr[k-2]] = overlay_bytes(shadow[rq_addr[k-2]], rq_be[k-2],
                                                     rq_data[k-2]);
            end
            if (k < RAND_OPS) begin
                // Mostly the same or a hot address so forwarding gets exercised
                pick = $urandom % 4;
                if (pick < 2) begin
                    rq_addr[k] = last_addr;
                end else if (pick == 2) begin
                    rq_addr[k] = hot[$urandom % 4];
                end else begin
                    rq_addr[k] = regbank_pkg::addr_t'($urandom);
                end
                rq_be[k]         = regbank_pkg::byte_en_t'($urandom);
                rq_data[k].whole = $urandom;
                last_addr        = rq_addr[k];
                wr_addr          = rq_addr[k];
                wr_be            = rq_be[k];
                wr_data          = rq_data[k];
            end else begin
                wr_be = '0;
            end
            // Half the reads target the word just written
            if (k >= 2 && k - 2 < RAND_OPS && ($urandom % 2) == 0) begin
                rd_addr = rq_addr[k-2];
            end else begin
                rd_addr = regbank_pkg::addr_t'($urandom);
            end
            @(negedge clk);
        end
        if (mismatches == 0) begin
            $display("PASS random_rmw");
        end else begin
            $display("DONE random_rmw with %0d mismatches", mismatches);
        end
    endtask

    initial begin : main
        bit ok;
        void'($urandom(32'h9f70));
        rst           = 1'b1;
        wr_addr       = '0;
        wr_be         = '0;
        wr_data       = '0;
        rd_addr       = '0;
        checks_passed = 0;
        checks_failed = 0;
        trace_ready   = 1'b0;
        load_trace(ok);
        if (!ok) begin
            $display("Trace file sim/regbank_trace.txt is missing or holds no operations");
            $display("Simulation failed");
            $finish;
        end else begin
            trace_ready = 1'b1;
            apply_reset();
            check_reset();
            replay_trace();
            run_random();
            $display("Checks passed %0d, failed %0d", checks_passed, checks_failed);
            if (checks_failed == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // Limit from trace length, random count and a reset margin
    initial begin : watchdog
        int limit_ns;
        wait (trace_ready);
        limit_ns = op_count * 20 + RAND_OPS * 40 + 500;
        #(limit_ns);
        $display("Run timed out after %0d ns without reaching the end", limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/regbank_pkg.sv
verilog/reg_bank.sv
verilog/rmw_read_stage.sv
verilog/byte_merge_stage.sv
verilog/regbank_byteen_top.sv
sim/regbank_byteen_tb.sv

// ==== sim/regbank_trace.txt ====
# W name addr be data        write request held for one cycle, all fields hex
# R name addr expected       read back once the pipeline has drained
W full_wr_a3      3 f 12345678
R full_rd_a3      3 12345678
W partial_b1      3 2 0000ab00
R partial_rd_b1   3 1234ab78
W partial_b03     3 9 cd0000ef
R partial_rd_b03  3 cd34abef
W b2b_full        5 f 11223344
W b2b_lo          5 1 000000aa
W b2b_hi          5 8 bb000000
W b2b_mid         5 6 00ccdd00
R b2b_rd          5 bbccddaa
W idle_a5         5 0 ffffffff
R idle_rd5        5 bbccddaa
W iso_a6          6 f 5a5a5a5a
W iso_a7          7 3 0000beef
R iso_rd6         6 5a5a5a5a
R iso_rd7         7 0000beef
R iso_rd5         5 bbccddaa
R iso_rd3         3 cd34abef
W gap_a9          9 f 01020304
W gap_aa          a f a0b0c0d0
W gap_a9b         9 4 00770000
R gap_rd9         9 01770304
R gap_rda         a a0b0c0d0
